//--- mips_lite.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/stage_if.sv
hdl/instr_rom.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/mips_lite_top.sv
verif/mips_lite_assert.sv
verif/mips_lite_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mips_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f mips_lite.f --top-module mips_lite_tb -o sim_mips_lite &&
{ ./obj_dir/sim_mips_lite +verilator+error+limit+100 2>&1 | tee sim.log; } &&
grep -q "All tests passed!" sim.log &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed, see sim.log"; exit 1; }

//--- verif/mips_lite_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_cfg.svh"

module mips_lite_tb;

    localparam int N_STORES   = 15;
    // cycles after reset before anything can reach the result stage
    localparam int PIPE_FILL  = 2;
    localparam int RUN_LIMIT  = 3000;
    localparam int HALT_LIMIT = 200;
    localparam int QUIET_CYC  = 50;

    logic        clk;
    logic        rst_n;
    logic        st_ready;
    logic        st_valid;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic        halted;

    int          seed;
    int          accepted;
    int          cycles;
    // store seen waiting on the previous cycle
    logic        held;
    logic [31:0] held_addr;
    logic [31:0] held_data;
    logic [31:0] exp_addr [N_STORES];
    logic [31:0] exp_data [N_STORES];

    mips_lite_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_valid (st_valid),
        .st_ready (st_ready),
        .st_addr  (st_addr),
        .st_data  (st_data),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s (time %0t)", why, $time);
        $display("Test failures found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("CHECK FAILED time %0t: %s expected 0x%08h actual 0x%08h",
                 $time, name, exp, act);
        abort_run("value check failed");
    endtask

    // data word k at reset
    function automatic logic [31:0] preload(input int k);
        return 32'(`DRAM_BASE_VAL + k * `DRAM_STEP);
    endfunction

    // one cycle: new st_ready on the falling edge, then the store checks
    task automatic step_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        rnd = $random(seed);
        // ready about three cycles of four
        st_ready = (rnd[1:0] != 2'b00);
        cycles++;
        assert (DUT.u_assert.fail_cnt == 0)
            else abort_run("protocol assertion failed on a stage link or the store port");
        assert (!(halted && accepted < N_STORES))
            else abort_run("halted rose before all stores were accepted");
        if (held) begin
            assert (st_valid) else abort_run("waiting store vanished before acceptance");
            assert (st_addr == held_addr) else value_mismatch("st_addr", held_addr, st_addr);
            assert (st_data == held_data) else value_mismatch("st_data", held_data, st_data);
        end
        // st_valid with this st_ready means a transfer on the next rising edge
        if (st_valid && st_ready) begin
            assert (accepted < N_STORES) else abort_run("store beyond the last expected one");
            assert (st_addr == exp_addr[accepted])
                else value_mismatch("st_addr", exp_addr[accepted], st_addr);
            assert (st_data == exp_data[accepted])
                else value_mismatch("st_data", exp_data[accepted], st_data);
            accepted++;
        end
        held      = st_valid && !st_ready;
        held_addr = st_addr;
        held_data = st_data;
    endtask

    initial begin
        seed     = 56219;
        rst_n    = 1'b0;
        st_ready = 1'b0;
        accepted = 0;
        cycles   = 0;
        held     = 1'b0;
        // r2..r15 stored in order, then r17 = word0 + word14
        for (int k = 0; k < N_STORES - 1; k++) begin
            exp_addr[k] = 32'h100 + 32'(4 * k);
            exp_data[k] = preload(k);
        end
        exp_addr[N_STORES-1] = 32'h138;
        exp_data[N_STORES-1] = preload(0) + preload(14);

        repeat (8) begin
            @(negedge clk);
        end
        assert (!st_valid && !halted) else abort_run("st_valid or halted high in reset");
        rst_n = 1'b1;

        for (int c = 0; c < PIPE_FILL; c++) begin
            step_cycle();
            assert (!st_valid) else value_mismatch("st_valid", 32'd0, 32'(st_valid));
            assert (!halted) else value_mismatch("halted", 32'd0, 32'(halted));
        end

        cycles = 0;
        while (accepted < N_STORES) begin
            assert (cycles < RUN_LIMIT) else abort_run("timeout waiting for the stores");
            step_cycle();
        end

        cycles = 0;
        while (!halted) begin
            assert (cycles < HALT_LIMIT) else abort_run("timeout waiting for halted");
            step_cycle();
        end

        // core stays quiet once halted
        for (int c = 0; c < QUIET_CYC; c++) begin
            step_cycle();
            assert (!st_valid) else value_mismatch("st_valid", 32'd0, 32'(st_valid));
            assert (halted) else value_mismatch("halted", 32'd1, 32'(halted));
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/mips_lite_assert.sv
`timescale 1ns/10ps
`default_nettype none

module mips_lite_assert
    import mips_pkg::*;
(
    input wire           clk,
    input wire           rst_n,
    input wire           dec_valid,
    input wire           dec_ready,
    input wire dec_pkt_t dec_payload,
    input wire           exe_valid,
    input wire           exe_ready,
    input wire exe_pkt_t exe_payload,
    input wire           st_valid,
    input wire           st_ready,
    input wire [31:0]    st_addr,
    input wire [31:0]    st_data,
    input wire           halted
);

    // failures seen so far, polled by the testbench
    int fail_cnt = 0;

    // decode holds its item until execute takes it
    a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_payload))
        else begin
            fail_cnt++;
            $error("dec_if valid or payload changed before the transfer");
        end

    // same hold rule between execute and result
    a_exe_hold: assert property (@(posedge clk) disable iff (!rst_n)
        exe_valid && !exe_ready |=> exe_valid && $stable(exe_payload))
        else begin
            fail_cnt++;
            $error("exe_if valid or payload changed before the transfer");
        end

    // external store port under back-pressure
    a_st_hold: assert property (@(posedge clk) disable iff (!rst_n)
        st_valid && !st_ready |=> st_valid && $stable(st_addr) && $stable(st_data))
        else begin
            fail_cnt++;
            $error("store port changed while waiting for st_ready");
        end

    // reset clears the outputs of the result stage
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !st_valid && !halted)
        else begin
            fail_cnt++;
            $error("st_valid or halted high right after a reset edge");
        end

    // no store follows the halt
    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> !st_valid)
        else begin
            fail_cnt++;
            $error("a store appeared after the halt");
        end

endmodule

bind mips_lite_top mips_lite_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid   (dec_if.valid),
    .dec_ready   (dec_if.ready),
    .dec_payload (dec_if.payload),
    .exe_valid   (exe_if.valid),
    .exe_ready   (exe_if.ready),
    .exe_payload (exe_if.payload),
    .st_valid    (st_valid),
    .st_ready    (st_ready),
    .st_addr     (st_addr),
    .st_data     (st_data),
    .halted      (halted)
);

`default_nettype wire

//--- hdl/mips_lite_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_lite_top
    import mips_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    output logic        st_valid,
    input  wire         st_ready,
    output logic [31:0] st_addr,
    output logic [31:0] st_data,
    output logic        halted
);

    logic [31:0] fetch_addr;
    instr_t      fetch_data;
    // writeback path from result back into the register file
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    stage_if #(.pkt_t(dec_pkt_t)) dec_if ();
    stage_if #(.pkt_t(exe_pkt_t)) exe_if ();

    instr_rom u_rom (
        .addr  (fetch_addr),
        .rdata (fetch_data)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .dec_out    (dec_if.src)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec_in  (dec_if.dst),
        .exe_out (exe_if.src)
    );

    result_stage u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .exe_in   (exe_if.dst),
        .wb_en    (wb_en),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .st_valid (st_valid),
        .st_ready (st_ready),
        .st_addr  (st_addr),
        .st_data  (st_data),
        .halted   (halted)
    );

endmodule

`default_nettype wire

//--- hdl/result_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_cfg.svh"

module result_stage
    import mips_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    stage_if.dst         exe_in,
    output logic         wb_en,
    output logic [4:0]   wb_reg,
    output logic [31:0]  wb_data,
    output logic         st_valid,
    input  wire          st_ready,
    output logic [31:0]  st_addr,
    output logic [31:0]  st_data,
    output logic         halted
);

    localparam int DRAM_AW = $clog2(`DRAM_WORDS);

    logic [31:0]        dram [`DRAM_WORDS];
    logic [DRAM_AW-1:0] widx;
    logic               is_store;
    logic               xfer;

    // power-up contents follow the preload rule
    initial begin
        for (int k = 0; k < `DRAM_WORDS; k++) begin
            dram[k] = 32'(`DRAM_BASE_VAL + k * `DRAM_STEP);
        end
    end

    assign widx     = exe_in.payload.res[DRAM_AW+1:2];
    assign is_store = (exe_in.payload.op == ALU_STORE);

    // store sits on the external port until accepted
    assign st_valid = exe_in.valid && is_store;
    assign st_addr  = exe_in.payload.res;
    assign st_data  = exe_in.payload.st_data;

    // non-stores always retire, stores wait for st_ready
    assign exe_in.ready = !is_store || st_ready;
    assign xfer         = exe_in.valid && exe_in.ready;

    // loads and alu ops write back in the cycle they arrive
    assign wb_en   = exe_in.valid && exe_in.payload.wen;
    assign wb_reg  = exe_in.payload.dst;
    assign wb_data = (exe_in.payload.op == ALU_LOAD) ? dram[widx] : exe_in.payload.res;

    always_ff @(posedge clk) begin
        if (xfer && is_store) begin
            dram[widx] <= exe_in.payload.st_data;
        end
    end

    // sticky once the delay-slot item retires
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (xfer && exe_in.payload.last) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n,
    stage_if.dst dec_in,
    stage_if.src exe_out
);

    exe_pkt_t nxt;

    // free slot, or the held item leaves on this edge
    assign dec_in.ready = !exe_out.valid || exe_out.ready;

    always_comb begin
        nxt.op      = dec_in.payload.op;
        nxt.st_data = dec_in.payload.rt_val;
        nxt.dst     = dec_in.payload.dst;
        nxt.wen     = dec_in.payload.wen;
        nxt.last    = dec_in.payload.last;
        // loads, stores and addiu all add the immediate to rs
        if (dec_in.payload.op == ALU_ADD_REG) begin
            nxt.res = dec_in.payload.rs_val + dec_in.payload.rt_val;
        end else begin
            nxt.res = dec_in.payload.rs_val + dec_in.payload.imm;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_out.valid <= 1'b0;
        end else if (dec_in.ready) begin
            exe_out.valid <= dec_in.valid;
        end
    end

    // one-entry holding register
    always_ff @(posedge clk) begin
        if (dec_in.valid && dec_in.ready) begin
            exe_out.payload <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_cfg.svh"

module decode_stage
    import mips_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    output logic [31:0]  fetch_addr,
    input  wire instr_t  fetch_data,
    input  wire          wb_en,
    input  wire [4:0]    wb_reg,
    input  wire [31:0]   wb_data,
    stage_if.src         dec_out
);

    logic [31:0] pc;
    // jr r0 seen, the next fetch is the delay slot
    logic        slot_next;
    // delay slot issued, fetch has stopped
    logic        fetch_done;
    logic [31:0] rf [32];
    // one bit per register with a write still in flight
    logic [31:0] pending;

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dst;
    logic        use_rs;
    logic        use_rt;
    logic        is_jr;
    logic        known;
    logic        wen;
    alu_op_e     op;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic        hazard;
    logic        can_load;
    logic        advance;
    dec_pkt_t    pkt;

    assign fetch_addr = pc;

    always_comb begin
        rs     = fetch_data.rs;
        rt     = fetch_data.rt;
        dst    = fetch_data.rt;
        op     = ALU_ADD_IMM;
        use_rs = 1'b1;
        use_rt = 1'b0;
        is_jr  = 1'b0;
        known  = 1'b1;
        case (fetch_data.opcode)
            OP_LW:    op = ALU_LOAD;
            OP_ADDIU: op = ALU_ADD_IMM;
            OP_SW: begin
                op     = ALU_STORE;
                use_rt = 1'b1;
            end
            OP_SPECIAL: begin
                if (fetch_data.lo.r.funct == FN_ADDU) begin
                    op     = ALU_ADD_REG;
                    use_rt = 1'b1;
                    dst    = fetch_data.lo.r.rd;
                end else if (fetch_data.lo.r.funct == FN_JR) begin
                    is_jr = 1'b1;
                end else begin
                    known  = 1'b0;
                    use_rs = 1'b0;
                end
            end
            default: begin
                known  = 1'b0;
                use_rs = 1'b0;
            end
        endcase
        // writes to r0 are dropped here so r0 never goes pending
        wen = known && !is_jr && (op != ALU_STORE) && (dst != 5'd0);
    end

    // operand read with same-cycle writeback bypass, r0 reads as zero
    assign rs_val = (rs == 5'd0) ? '0 : (wb_en && wb_reg == rs) ? wb_data : rf[rs];
    assign rt_val = (rt == 5'd0) ? '0 : (wb_en && wb_reg == rt) ? wb_data : rf[rt];

    // the dest check keeps a single pending bit per register enough
    assign hazard = (use_rs && pending[rs]) || (use_rt && pending[rt]) ||
                    (wen && pending[dst]);
    assign can_load = !dec_out.valid || dec_out.ready;
    assign advance  = !fetch_done && can_load && !hazard;

    always_comb begin
        pkt.op     = op;
        pkt.rs_val = rs_val;
        pkt.rt_val = rt_val;
        pkt.imm    = {{16{fetch_data.lo.imm[15]}}, fetch_data.lo.imm};
        pkt.dst    = dst;
        pkt.wen    = wen;
        pkt.last   = slot_next;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc            <= `RESET_VECTOR;
            slot_next     <= 1'b0;
            fetch_done    <= 1'b0;
            pending       <= '0;
            dec_out.valid <= 1'b0;
        end else begin
            if (dec_out.valid && dec_out.ready) begin
                dec_out.valid <= 1'b0;
            end
            if (wb_en) begin
                pending[wb_reg] <= 1'b0;
            end
            if (advance) begin
                pc <= pc + 32'd4;
                // jr stays in decode, nothing goes downstream for it
                if (is_jr) begin
                    if (rs_val == '0) begin
                        slot_next <= 1'b1;
                    end else begin
                        pc <= rs_val;
                    end
                end else if (known) begin
                    dec_out.valid <= 1'b1;
                    if (wen) begin
                        pending[dst] <= 1'b1;
                    end
                end
                if (slot_next) begin
                    fetch_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && known && !is_jr) begin
            dec_out.payload <= pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en && wb_reg != 5'd0) begin
            rf[wb_reg] <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/instr_rom.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_cfg.svh"

module instr_rom
    import mips_pkg::*;
(
    input  wire [31:0] addr,
    output instr_t     rdata
);

    localparam int IRAM_AW = $clog2(`IRAM_WORDS);

    logic [31:0] mem [`IRAM_WORDS];
    logic [31:0] byte_off;

    function automatic logic [31:0] enc_i(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          funct_e fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    // program image built at elaboration
    initial begin
        int w;
        // unused words decode as sll r0, which decode skips
        for (int k = 0; k < `IRAM_WORDS; k++) begin
            mem[k] = '0;
        end
        w = 0;
        // lw r(k+2), 4k(r0) pulls data words 0..14 into r2..r16
        for (int k = 0; k < 15; k++) begin
            mem[w] = enc_i(OP_LW, 5'd0, 5'(k + 2), 16'(4 * k));
            w++;
        end
        // sw r(k+2), 0x100+4k(r0) for r2..r15
        for (int k = 0; k < 14; k++) begin
            mem[w] = enc_i(OP_SW, 5'd0, 5'(k + 2), 16'(16'h100 + 4 * k));
            w++;
        end
        // r17 = r2 + r16, then store it right after the others
        mem[w] = enc_r(5'd2, 5'd16, 5'd17, FN_ADDU);
        w++;
        mem[w] = enc_i(OP_SW, 5'd0, 5'd17, 16'h0138);
        w++;
        // jr r0 halts once the delay slot has gone through
        mem[w] = enc_r(5'd0, 5'd0, 5'd0, FN_JR);
        w++;
        // delay slot, addiu r2, r0, 0
        mem[w] = enc_i(OP_ADDIU, 5'd0, 5'd2, 16'h0000);
    end

    // word index relative to the reset vector
    assign byte_off = addr - `RESET_VECTOR;
    assign rdata    = mem[byte_off[IRAM_AW+1:2]];

endmodule

`default_nettype wire

//--- hdl/stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// valid/ready link between two pipeline stages
interface stage_if #(
    parameter type pkt_t = logic
);

    logic valid;
    logic ready;
    // held steady by the source from valid rise until the transfer
    pkt_t payload;

    modport src (output valid, output payload, input ready);

    modport dst (input valid, input payload, output ready);

endinterface

`default_nettype wire

//--- hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // funct field values under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001
    } funct_e;

    // low half of an r-type word
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } rtype_lo_t;

    // low 16 bits seen either as r-type fields or as an immediate
    typedef union packed {
        rtype_lo_t   r;
        logic [15:0] imm;
    } instr_lo_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        instr_lo_t  lo;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD_IMM = 2'd0,
        ALU_ADD_REG = 2'd1,
        ALU_LOAD    = 2'd2,
        ALU_STORE   = 2'd3
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        alu_op_e     op;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [4:0]  dst;
        logic        wen;
        logic        last;
    } dec_pkt_t;

    // execute to result
    typedef struct packed {
        alu_op_e     op;
        // alu sum, or the byte address for lw and sw
        logic [31:0] res;
        logic [31:0] st_data;
        logic [4:0]  dst;
        logic        wen;
        logic        last;
    } exe_pkt_t;

endpackage

`default_nettype wire

//--- hdl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// fetch starts here after reset, also the base of the instruction memory
`define RESET_VECTOR 32'hBFC00000

// instruction memory depth in 32-bit words
`define IRAM_WORDS 4096

// data memory depth in 32-bit words
`define DRAM_WORDS 256

// data memory preload
// word k holds DRAM_BASE_VAL + k * DRAM_STEP
`define DRAM_BASE_VAL 7
`define DRAM_STEP 5

`endif
